// File: all.f
+incdir+.
cache_pkg.sv
cache_if.sv
cache_line_rw.sv
axi_lite_line_master.sv
dcache_ctrl.sv
dcache_top.sv
tb_axi_mem.sv
dcache_sva.sv
tb_dcache.sv

// File: axi_lite_line_master.sv
// ******************************
// axi4-lite line bridge
// splits one line transfer into eight
// single 64-bit transactions in order
// ******************************

`timescale 1ns/1ps
`include "cache_defines.svh"

module axi_lite_line_master (
  input  logic                       clk,
  input  logic                       rst,
  line_xfer_if.slave                 line_xfer,
  // write address
  output logic                       o_awvalid,
  input  logic                       i_awready,
  output logic [`CACHE_ADDR_W-1:0]   o_awaddr,
  // write data
  output logic                       o_wvalid,
  input  logic                       i_wready,
  output logic [`CACHE_BEAT_W-1:0]   o_wdata,
  output logic [`CACHE_BEAT_W/8-1:0] o_wstrb,
  // write response, bresp ignored
  input  logic                       i_bvalid,
  output logic                       o_bready,
  // read address
  output logic                       o_arvalid,
  input  logic                       i_arready,
  output logic [`CACHE_ADDR_W-1:0]   o_araddr,
  // read data, rresp ignored
  input  logic                       i_rvalid,
  output logic                       o_rready,
  input  logic [`CACHE_BEAT_W-1:0]   i_rdata
);

  localparam int BEAT_CNT_W = $clog2(`CACHE_BEATS);
  // byte offset bits within one beat
  localparam int BEAT_LSB = $clog2(`CACHE_BEAT_W / 8);
  localparam logic [BEAT_CNT_W-1:0] LAST_BEAT = BEAT_CNT_W'(`CACHE_BEATS - 1);

  cache_pkg::xfer_state_e state_q;
  logic [BEAT_CNT_W-1:0]    beat_q;
  // read beats shift in from the top
  logic [`CACHE_LINE_W-1:0] line_q;
  logic [`CACHE_ADDR_W-1:0] beat_addr;
  logic is_write;
  logic aw_done;
  logic w_done;
  logic beat_fire;
  logic last_beat;
  logic launch_beat;

  assign is_write = (line_xfer.op == cache_pkg::LINE_WRITE);

  // line base plus 8 bytes per beat
  assign beat_addr = line_xfer.addr +
                     {{(`CACHE_ADDR_W - BEAT_CNT_W - BEAT_LSB){1'b0}},
                      beat_q, {BEAT_LSB{1'b0}}};

  // aw and w drop independently
  assign aw_done = ~o_awvalid | i_awready;
  assign w_done  = ~o_wvalid | i_wready;

  // response for current beat
  assign beat_fire = is_write ? (i_bvalid & o_bready) : (i_rvalid & o_rready);
  assign last_beat = (beat_q == LAST_BEAT);

  // first beat on a new line, or the next one after a response
  assign launch_beat = ((state_q == cache_pkg::XFER_IDLE) & line_xfer.valid) |
                       ((state_q == cache_pkg::XFER_RESP) & beat_fire & ~last_beat);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= cache_pkg::XFER_IDLE;
      beat_q    <= '0;
      o_awvalid <= 1'b0;
      o_wvalid  <= 1'b0;
      o_arvalid <= 1'b0;
      o_bready  <= 1'b0;
      o_rready  <= 1'b0;
    end else begin
      case (state_q)
        cache_pkg::XFER_IDLE: begin
          if (line_xfer.valid) begin
            beat_q  <= '0;
            state_q <= cache_pkg::XFER_ADDR;
          end
        end
        cache_pkg::XFER_ADDR: begin
          if (o_awvalid && i_awready) begin
            o_awvalid <= 1'b0;
          end
          if (o_wvalid && i_wready) begin
            o_wvalid <= 1'b0;
          end
          if (o_arvalid && i_arready) begin
            o_arvalid <= 1'b0;
          end
          // both write channels accepted, wait for b
          if (is_write && aw_done && w_done) begin
            o_bready <= 1'b1;
            state_q  <= cache_pkg::XFER_RESP;
          end
          if (!is_write && o_arvalid && i_arready) begin
            o_rready <= 1'b1;
            state_q  <= cache_pkg::XFER_RESP;
          end
        end
        cache_pkg::XFER_RESP: begin
          if (beat_fire) begin
            o_bready <= 1'b0;
            o_rready <= 1'b0;
            if (last_beat) begin
              state_q <= cache_pkg::XFER_DONE;
            end else begin
              beat_q  <= beat_q + 1'b1;
              state_q <= cache_pkg::XFER_ADDR;
            end
          end
        end
        // ready is up this cycle, valid completes the line
        cache_pkg::XFER_DONE: begin
          state_q <= cache_pkg::XFER_IDLE;
        end
        default: begin
          state_q <= cache_pkg::XFER_IDLE;
        end
      endcase
      if (launch_beat) begin
        o_awvalid <= is_write;
        o_wvalid  <= is_write;
        o_arvalid <= ~is_write;
      end
    end
  end

  // beat 0 ends up in the low bits after eight shifts
  always_ff @(posedge clk) begin
    if (state_q == cache_pkg::XFER_RESP && !is_write && beat_fire) begin
      line_q <= {i_rdata, line_q[`CACHE_LINE_W-1:`CACHE_BEAT_W]};
    end
  end

  // payload fixed while a valid is up, beat_q only moves in resp
  assign o_awaddr = beat_addr;
  assign o_araddr = beat_addr;
  assign o_wdata  = line_xfer.wdata[beat_q*`CACHE_BEAT_W +: `CACHE_BEAT_W];
  // whole beats only
  assign o_wstrb  = '1;

  assign line_xfer.ready = (state_q == cache_pkg::XFER_DONE);
  assign line_xfer.rdata = line_q;

endmodule

// File: cache_defines.svh
// ******************************
// data cache geometry
// address, line and bus beat sizes
// ******************************

`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// byte address width
`define CACHE_ADDR_W 32
// bytes per cache line
`define CACHE_LINE_BYTES 64
// direct-mapped, one line per index
`define CACHE_NUM_LINES 16
// bus beats per line transfer
`define CACHE_BEATS 8
// beat width, also the cpu word
`define CACHE_BEAT_W 64
// whole line in bits
`define CACHE_LINE_W 512

`endif

// File: cache_if.sv
// ******************************
// line request and line transfer
// interfaces inside the cache
// ******************************

`timescale 1ns/1ps
`include "cache_defines.svh"

// controller to line request unit
interface line_req_if;
  logic                     req;
  cache_pkg::line_op_e      op;
  logic [`CACHE_ADDR_W-1:0] addr;
  logic [`CACHE_LINE_W-1:0] wdata;
  logic [`CACHE_LINE_W-1:0] rdata;
  // one-cycle pulse, rdata valid with it
  logic                     ack;

  modport requester (output req, op, addr, wdata, input rdata, ack);
  modport servicer (input req, op, addr, wdata, output rdata, ack);
endinterface

// line request unit to bus bridge
interface line_xfer_if;
  logic                     valid;
  // high for the single cycle that completes the line
  logic                     ready;
  cache_pkg::line_op_e      op;
  logic [`CACHE_ADDR_W-1:0] addr;
  logic [`CACHE_LINE_W-1:0] wdata;
  logic [`CACHE_LINE_W-1:0] rdata;

  modport master (output valid, op, addr, wdata, input ready, rdata);
  modport slave (input valid, op, addr, wdata, output ready, rdata);
endinterface

// File: cache_line_rw.sv
// ******************************
// line request unit
// starts one bus line transfer per fresh
// request, acks one cycle after it ends
// ******************************

`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_line_rw (
  input  logic         clk,
  input  logic         rst,
  line_req_if.servicer line_req,
  line_xfer_if.master  line_xfer
);

  // req seen last cycle
  logic req_q;
  logic xfer_valid_q;
  logic ack_q;
  // returned line, held for the ack cycle
  logic [`CACHE_LINE_W-1:0] rdata_q;
  logic start;
  logic xfer_done;

  // only a rising req starts a transfer,
  // so a req still high around ack cannot restart one
  assign start     = line_req.req & ~req_q & ~xfer_valid_q;
  assign xfer_done = xfer_valid_q & line_xfer.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q        <= 1'b0;
      xfer_valid_q <= 1'b0;
      ack_q        <= 1'b0;
    end else begin
      req_q <= line_req.req;
      // ack lands one cycle after the handshake
      ack_q <= xfer_done;
      if (xfer_done) begin
        xfer_valid_q <= 1'b0;
      end else if (start) begin
        xfer_valid_q <= 1'b1;
      end
    end
  end

  // capture line on completion
  always_ff @(posedge clk) begin
    if (xfer_done) begin
      rdata_q <= line_xfer.rdata;
    end
  end

  assign line_xfer.valid = xfer_valid_q;
  assign line_xfer.op    = line_req.op;
  // line base, offset bits cleared
  assign line_xfer.addr  = {line_req.addr[`CACHE_ADDR_W-1:cache_pkg::OFFSET_W],
                            {cache_pkg::OFFSET_W{1'b0}}};
  assign line_xfer.wdata = line_req.wdata;

  assign line_req.rdata = rdata_q;
  assign line_req.ack   = ack_q;

endmodule

// File: cache_pkg.sv
// ******************************
// data cache package
// address fields and fsm state types
// ******************************

`include "cache_defines.svh"

package cache_pkg;

  // byte within line
  localparam int OFFSET_W = $clog2(`CACHE_LINE_BYTES);
  // line index
  localparam int INDEX_W = $clog2(`CACHE_NUM_LINES);
  // remaining upper address bits
  localparam int TAG_W = `CACHE_ADDR_W - INDEX_W - OFFSET_W;

  // whole-line operation, 0 read, 1 write
  typedef enum logic {
    LINE_READ  = 1'b0,
    LINE_WRITE = 1'b1
  } line_op_e;

  // cache controller
  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_LOOKUP,
    CTRL_EVICT,
    CTRL_REFILL,
    CTRL_RESPOND
  } ctrl_state_e;

  // bus bridge, one beat per pass through addr/resp
  typedef enum logic [1:0] {
    XFER_IDLE,
    XFER_ADDR,
    XFER_RESP,
    XFER_DONE
  } xfer_state_e;

endpackage

// File: dcache_ctrl.sv
// ******************************
// data cache controller
// tag/valid/dirty and line arrays,
// hit/miss fsm and cpu port
// ******************************

`timescale 1ns/1ps
`include "cache_defines.svh"

module dcache_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  // cpu request
  input  logic                       i_cpu_valid,
  output logic                       o_cpu_ready,
  input  logic                       i_cpu_we,
  input  logic [`CACHE_ADDR_W-1:0]   i_cpu_addr,
  input  logic [`CACHE_BEAT_W-1:0]   i_cpu_wdata,
  input  logic [`CACHE_BEAT_W/8-1:0] i_cpu_wstrb,
  // cpu response
  output logic                       o_cpu_done,
  output logic [`CACHE_BEAT_W-1:0]   o_cpu_rdata,
  line_req_if.requester              line_req
);

  // byte offset bits of one cpu word
  localparam int WORD_LSB = $clog2(`CACHE_BEAT_W / 8);
  localparam int WORD_W   = cache_pkg::OFFSET_W - WORD_LSB;

  cache_pkg::ctrl_state_e state_q;
  logic line_req_q;

  // storage arrays
  logic [cache_pkg::TAG_W-1:0] tag_q [`CACHE_NUM_LINES];
  logic [`CACHE_LINE_W-1:0]    line_q [`CACHE_NUM_LINES];
  logic [`CACHE_NUM_LINES-1:0] valid_q;
  logic [`CACHE_NUM_LINES-1:0] dirty_q;

  // registered cpu request
  logic                       req_we_q;
  logic [`CACHE_ADDR_W-1:0]   req_addr_q;
  logic [`CACHE_BEAT_W-1:0]   req_wdata_q;
  logic [`CACHE_BEAT_W/8-1:0] req_wstrb_q;

  // address fields
  logic [cache_pkg::TAG_W-1:0]   req_tag;
  logic [cache_pkg::INDEX_W-1:0] req_index;
  logic [WORD_W-1:0]             req_word;

  logic [`CACHE_LINE_W-1:0] cur_line;
  logic [`CACHE_BEAT_W-1:0] cur_word;
  logic [`CACHE_BEAT_W-1:0] merged_word;
  logic [`CACHE_ADDR_W-1:0] victim_addr;
  logic hit;

  assign req_tag   = req_addr_q[`CACHE_ADDR_W-1 -: cache_pkg::TAG_W];
  assign req_index = req_addr_q[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
  // low 3 bits dropped, word aligned
  assign req_word  = req_addr_q[cache_pkg::OFFSET_W-1:WORD_LSB];

  assign cur_line = line_q[req_index];
  assign cur_word = cur_line[req_word*`CACHE_BEAT_W +: `CACHE_BEAT_W];
  assign hit      = valid_q[req_index] & (tag_q[req_index] == req_tag);

  // evicted line goes back to where it came from
  assign victim_addr = {tag_q[req_index], req_index, {cache_pkg::OFFSET_W{1'b0}}};

  // byte merge under strobe
  always_comb begin
    merged_word = cur_word;
    for (int b = 0; b < `CACHE_BEAT_W / 8; b++) begin
      if (req_wstrb_q[b]) begin
        merged_word[b*8 +: 8] = req_wdata_q[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= cache_pkg::CTRL_IDLE;
      line_req_q <= 1'b0;
      valid_q    <= '0;
      dirty_q    <= '0;
    end else begin
      case (state_q)
        cache_pkg::CTRL_IDLE: begin
          if (i_cpu_valid) begin
            state_q <= cache_pkg::CTRL_LOOKUP;
          end
        end
        cache_pkg::CTRL_LOOKUP: begin
          if (hit) begin
            if (req_we_q) begin
              dirty_q[req_index] <= 1'b1;
            end
            state_q <= cache_pkg::CTRL_RESPOND;
          end else if (valid_q[req_index] && dirty_q[req_index]) begin
            line_req_q <= 1'b1;
            state_q    <= cache_pkg::CTRL_EVICT;
          end else begin
            // clean or empty line, refill straight away
            state_q <= cache_pkg::CTRL_REFILL;
          end
        end
        cache_pkg::CTRL_EVICT: begin
          if (line_req.ack) begin
            line_req_q         <= 1'b0;
            dirty_q[req_index] <= 1'b0;
            state_q            <= cache_pkg::CTRL_REFILL;
          end
        end
        cache_pkg::CTRL_REFILL: begin
          if (line_req.ack) begin
            line_req_q         <= 1'b0;
            valid_q[req_index] <= 1'b1;
            dirty_q[req_index] <= 1'b0;
            // redo the access, it hits now
            state_q            <= cache_pkg::CTRL_LOOKUP;
          end else begin
            // req low for one cycle after an evict, then raised
            line_req_q <= 1'b1;
          end
        end
        cache_pkg::CTRL_RESPOND: begin
          state_q <= cache_pkg::CTRL_IDLE;
        end
        default: begin
          state_q <= cache_pkg::CTRL_IDLE;
        end
      endcase
    end
  end

  // payload and storage updates
  always_ff @(posedge clk) begin
    if (o_cpu_ready && i_cpu_valid) begin
      req_we_q    <= i_cpu_we;
      req_addr_q  <= i_cpu_addr;
      req_wdata_q <= i_cpu_wdata;
      req_wstrb_q <= i_cpu_wstrb;
    end
    if (state_q == cache_pkg::CTRL_LOOKUP && hit) begin
      if (req_we_q) begin
        line_q[req_index][req_word*`CACHE_BEAT_W +: `CACHE_BEAT_W] <= merged_word;
      end
      // stores return the merged word
      o_cpu_rdata <= req_we_q ? merged_word : cur_word;
    end
    if (state_q == cache_pkg::CTRL_REFILL && line_req.ack) begin
      line_q[req_index] <= line_req.rdata;
      tag_q[req_index]  <= req_tag;
    end
  end

  assign o_cpu_ready = (state_q == cache_pkg::CTRL_IDLE);
  assign o_cpu_done  = (state_q == cache_pkg::CTRL_RESPOND);

  // line request, held steady while req is up
  assign line_req.req   = line_req_q;
  assign line_req.op    = (state_q == cache_pkg::CTRL_EVICT) ? cache_pkg::LINE_WRITE
                                                             : cache_pkg::LINE_READ;
  assign line_req.addr  = (state_q == cache_pkg::CTRL_EVICT) ? victim_addr : req_addr_q;
  assign line_req.wdata = cur_line;

endmodule

// File: dcache_sva.sv
// ******************************
// protocol assertions
// axi valids, cpu handshake, line ack
// ******************************

`timescale 1ns/1ps
`include "cache_defines.svh"

module dcache_sva (
  input logic                       clk,
  input logic                       rst,
  input logic                       i_awvalid,
  input logic                       i_awready,
  input logic [`CACHE_ADDR_W-1:0]   i_awaddr,
  input logic                       i_wvalid,
  input logic                       i_wready,
  input logic [`CACHE_BEAT_W-1:0]   i_wdata,
  input logic                       i_arvalid,
  input logic                       i_arready,
  input logic [`CACHE_ADDR_W-1:0]   i_araddr,
  input logic                       i_cpu_ready,
  input logic                       i_cpu_done,
  input logic                       i_ack
);

  // assertion failures so far
  int fail_count = 0;

  // aw held with its address until accepted
  assert property (@(posedge clk) disable iff (rst)
    i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
    else begin
      fail_count++;
      $error("awvalid or awaddr changed before acceptance");
    end

  // w held with its data
  assert property (@(posedge clk) disable iff (rst)
    i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata))
    else begin
      fail_count++;
      $error("wvalid or wdata changed before acceptance");
    end

  assert property (@(posedge clk) disable iff (rst)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else begin
      fail_count++;
      $error("arvalid or araddr changed before acceptance");
    end

  // done only outside idle
  assert property (@(posedge clk) disable iff (rst)
    $rose(i_cpu_done) |-> !i_cpu_ready)
    else begin
      fail_count++;
      $error("cpu done rose while cpu ready was high");
    end

  // single cycle ack
  assert property (@(posedge clk) disable iff (rst)
    i_ack |=> !i_ack)
    else begin
      fail_count++;
      $error("line ack longer than one cycle");
    end

endmodule

bind dcache_top dcache_sva u_sva (
  .clk         (clk),
  .rst         (rst),
  .i_awvalid   (o_awvalid),
  .i_awready   (i_awready),
  .i_awaddr    (o_awaddr),
  .i_wvalid    (o_wvalid),
  .i_wready    (i_wready),
  .i_wdata     (o_wdata),
  .i_arvalid   (o_arvalid),
  .i_arready   (i_arready),
  .i_araddr    (o_araddr),
  .i_cpu_ready (o_cpu_ready),
  .i_cpu_done  (o_cpu_done),
  .i_ack       (line_req.ack)
);

// File: dcache_top.sv
// ******************************
// write-back data cache top
// cpu load/store port to axi4-lite
// ******************************

`timescale 1ns/1ps
`include "cache_defines.svh"

module dcache_top (
  input  logic                       clk,
  input  logic                       rst,
  // cpu port
  input  logic                       i_cpu_valid,
  output logic                       o_cpu_ready,
  input  logic                       i_cpu_we,
  input  logic [`CACHE_ADDR_W-1:0]   i_cpu_addr,
  input  logic [`CACHE_BEAT_W-1:0]   i_cpu_wdata,
  input  logic [`CACHE_BEAT_W/8-1:0] i_cpu_wstrb,
  output logic                       o_cpu_done,
  output logic [`CACHE_BEAT_W-1:0]   o_cpu_rdata,
  // axi4-lite master
  output logic                       o_awvalid,
  input  logic                       i_awready,
  output logic [`CACHE_ADDR_W-1:0]   o_awaddr,
  output logic                       o_wvalid,
  input  logic                       i_wready,
  output logic [`CACHE_BEAT_W-1:0]   o_wdata,
  output logic [`CACHE_BEAT_W/8-1:0] o_wstrb,
  input  logic                       i_bvalid,
  output logic                       o_bready,
  output logic                       o_arvalid,
  input  logic                       i_arready,
  output logic [`CACHE_ADDR_W-1:0]   o_araddr,
  input  logic                       i_rvalid,
  output logic                       o_rready,
  input  logic [`CACHE_BEAT_W-1:0]   i_rdata
);

  // controller to line unit
  line_req_if  line_req ();
  // line unit to bridge
  line_xfer_if line_xfer ();

  dcache_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .i_cpu_valid (i_cpu_valid),
    .o_cpu_ready (o_cpu_ready),
    .i_cpu_we    (i_cpu_we),
    .i_cpu_addr  (i_cpu_addr),
    .i_cpu_wdata (i_cpu_wdata),
    .i_cpu_wstrb (i_cpu_wstrb),
    .o_cpu_done  (o_cpu_done),
    .o_cpu_rdata (o_cpu_rdata),
    .line_req    (line_req.requester)
  );

  cache_line_rw u_line_rw (
    .clk       (clk),
    .rst       (rst),
    .line_req  (line_req.servicer),
    .line_xfer (line_xfer.master)
  );

  axi_lite_line_master u_axi_master (
    .clk       (clk),
    .rst       (rst),
    .line_xfer (line_xfer.slave),
    .o_awvalid (o_awvalid),
    .i_awready (i_awready),
    .o_awaddr  (o_awaddr),
    .o_wvalid  (o_wvalid),
    .i_wready  (i_wready),
    .o_wdata   (o_wdata),
    .o_wstrb   (o_wstrb),
    .i_bvalid  (i_bvalid),
    .o_bready  (o_bready),
    .o_arvalid (o_arvalid),
    .i_arready (i_arready),
    .o_araddr  (o_araddr),
    .i_rvalid  (i_rvalid),
    .o_rready  (o_rready),
    .i_rdata   (i_rdata)
  );

endmodule

// File: tb_axi_mem.sv
// ******************************
// axi4-lite memory model
// byte array with random ready delays,
// one transaction at a time
// ******************************

`timescale 1ns/1ps
`include "cache_defines.svh"

module tb_axi_mem (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_awvalid,
  output logic                       o_awready,
  input  logic [`CACHE_ADDR_W-1:0]   i_awaddr,
  input  logic                       i_wvalid,
  output logic                       o_wready,
  input  logic [`CACHE_BEAT_W-1:0]   i_wdata,
  input  logic [`CACHE_BEAT_W/8-1:0] i_wstrb,
  output logic                       o_bvalid,
  input  logic                       i_bready,
  input  logic                       i_arvalid,
  output logic                       o_arready,
  input  logic [`CACHE_ADDR_W-1:0]   i_araddr,
  output logic                       o_rvalid,
  input  logic                       i_rready,
  output logic [`CACHE_BEAT_W-1:0]   o_rdata
);

  // 64 KiB is enough for the tags in use
  localparam int MEM_BYTES = 65536;

  logic [7:0] mem [MEM_BYTES];
  // accepted aw and ar beats, read by the testbench
  int aw_count;
  int ar_count;

  // 0 to 3 idle cycles
  task automatic random_wait();
    repeat ($urandom_range(3, 0)) @(posedge clk);
  endtask

  task automatic serve_write();
    logic [`CACHE_ADDR_W-1:0]   addr;
    logic [`CACHE_BEAT_W-1:0]   data;
    logic [`CACHE_BEAT_W/8-1:0] strb;
    random_wait();
    #1;
    // aw and w accepted together
    o_awready = 1'b1;
    o_wready  = 1'b1;
    @(posedge clk);
    addr = i_awaddr;
    data = i_wdata;
    strb = i_wstrb;
    aw_count++;
    #1;
    o_awready = 1'b0;
    o_wready  = 1'b0;
    for (int b = 0; b < `CACHE_BEAT_W / 8; b++) begin
      if (strb[b]) begin
        mem[addr[15:0] + b] = data[b*8 +: 8];
      end
    end
    random_wait();
    #1 o_bvalid = 1'b1;
    do @(posedge clk); while (!i_bready);
    #1 o_bvalid = 1'b0;
  endtask

  task automatic serve_read();
    logic [`CACHE_ADDR_W-1:0] addr;
    random_wait();
    #1 o_arready = 1'b1;
    @(posedge clk);
    addr = i_araddr;
    ar_count++;
    #1 o_arready = 1'b0;
    // little endian, lowest byte in bits 7:0
    for (int b = 0; b < `CACHE_BEAT_W / 8; b++) begin
      o_rdata[b*8 +: 8] = mem[addr[15:0] + b];
    end
    random_wait();
    #1 o_rvalid = 1'b1;
    do @(posedge clk); while (!i_rready);
    #1 o_rvalid = 1'b0;
  endtask

  initial begin
    o_awready = 1'b0;
    o_wready  = 1'b0;
    o_bvalid  = 1'b0;
    o_arready = 1'b0;
    o_rvalid  = 1'b0;
    o_rdata   = '0;
    aw_count  = 0;
    ar_count  = 0;
    // preset, low address byte plus next byte up
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem[a] = a[7:0] + a[15:8];
    end
    forever begin
      @(posedge clk);
      if (!rst && i_awvalid && i_wvalid) begin
        serve_write();
      end else if (!rst && i_arvalid) begin
        serve_read();
      end
    end
  end

endmodule

// File: tb_dcache.sv
// ******************************
// data cache testbench
// directed tests against a shadow
// memory and an axi4-lite model
// ******************************

`timescale 1ns/1ps
`include "cache_defines.svh"

module tb_dcache;

  localparam int RESET_CYCLES      = 16;
  localparam int CYCLES_PER_ACCESS = 200;
  localparam int SWEEP_ACCESSES    = 64;
  // miss, hit, store and load, evict, then the sweep
  localparam int NUM_ACCESSES      = 5 + SWEEP_ACCESSES;
  localparam logic [31:0] SEED     = 32'h5358_774e;

  logic clk;
  logic rst;
  logic cpu_valid;
  logic cpu_ready;
  logic cpu_we;
  logic [`CACHE_ADDR_W-1:0]   cpu_addr;
  logic [`CACHE_BEAT_W-1:0]   cpu_wdata;
  logic [`CACHE_BEAT_W/8-1:0] cpu_wstrb;
  logic cpu_done;
  logic [`CACHE_BEAT_W-1:0]   cpu_rdata;
  logic awvalid;
  logic awready;
  logic [`CACHE_ADDR_W-1:0]   awaddr;
  logic wvalid;
  logic wready;
  logic [`CACHE_BEAT_W-1:0]   wdata;
  logic [`CACHE_BEAT_W/8-1:0] wstrb;
  logic bvalid;
  logic bready;
  logic arvalid;
  logic arready;
  logic [`CACHE_ADDR_W-1:0]   araddr;
  logic rvalid;
  logic rready;
  logic [`CACHE_BEAT_W-1:0]   rdata;

  // expected memory contents, byte per address
  logic [7:0] shadow [65536];

  dcache_top dut (
    .clk (clk), .rst (rst),
    .i_cpu_valid (cpu_valid), .o_cpu_ready (cpu_ready), .i_cpu_we (cpu_we),
    .i_cpu_addr (cpu_addr), .i_cpu_wdata (cpu_wdata), .i_cpu_wstrb (cpu_wstrb),
    .o_cpu_done (cpu_done), .o_cpu_rdata (cpu_rdata),
    .o_awvalid (awvalid), .i_awready (awready), .o_awaddr (awaddr),
    .o_wvalid (wvalid), .i_wready (wready), .o_wdata (wdata), .o_wstrb (wstrb),
    .i_bvalid (bvalid), .o_bready (bready),
    .o_arvalid (arvalid), .i_arready (arready), .o_araddr (araddr),
    .i_rvalid (rvalid), .o_rready (rready), .i_rdata (rdata)
  );

  tb_axi_mem mem_model (
    .clk (clk), .rst (rst),
    .i_awvalid (awvalid), .o_awready (awready), .i_awaddr (awaddr),
    .i_wvalid (wvalid), .o_wready (wready), .i_wdata (wdata), .i_wstrb (wstrb),
    .o_bvalid (bvalid), .i_bready (bready),
    .i_arvalid (arvalid), .o_arready (arready), .i_araddr (araddr),
    .o_rvalid (rvalid), .i_rready (rready), .o_rdata (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [`CACHE_BEAT_W-1:0] got,
                            input logic [`CACHE_BEAT_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // single-bit status outputs
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // word from the shadow, address truncated to 8 bytes
  function automatic logic [`CACHE_BEAT_W-1:0] expected_word(input logic [31:0] addr);
    logic [`CACHE_BEAT_W-1:0] w;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = shadow[{addr[15:3], 3'd0} + b];
    end
    return w;
  endfunction

  // word as the memory model holds it
  function automatic logic [`CACHE_BEAT_W-1:0] model_word(input logic [31:0] addr);
    logic [`CACHE_BEAT_W-1:0] w;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = mem_model.mem[{addr[15:3], 3'd0} + b];
    end
    return w;
  endfunction

  // one request, returns data and cycles from accept to done
  task automatic cpu_access(input logic we, input logic [31:0] addr,
                            input logic [63:0] data, input logic [7:0] strb,
                            output logic [63:0] result, output int cycles);
    @(posedge clk);
    #1;
    cpu_valid = 1'b1;
    cpu_we    = we;
    cpu_addr  = addr;
    cpu_wdata = data;
    cpu_wstrb = strb;
    do @(posedge clk); while (!cpu_ready);
    #1 cpu_valid = 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!cpu_done);
    result = cpu_rdata;
  endtask

  task automatic load_check(input logic [31:0] addr, output int cycles);
    logic [63:0] result;
    cpu_access(1'b0, addr, '0, '0, result, cycles);
    check_word("o_cpu_rdata", result, expected_word(addr));
  endtask

  // stores return the merged word
  task automatic store_check(input logic [31:0] addr, input logic [63:0] data,
                             input logic [7:0] strb);
    logic [63:0] result;
    int cycles;
    cpu_access(1'b1, addr, data, strb, result, cycles);
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        shadow[{addr[15:3], 3'd0} + b] = data[b*8 +: 8];
      end
    end
    check_word("o_cpu_rdata", result, expected_word(addr));
  endtask

  // index 5, tag 0, empty after reset
  task automatic read_miss_refill();
    int ar_before;
    int cycles;
    ar_before = mem_model.ar_count;
    load_check(32'h0000_0148, cycles);
    check_count("ar count", mem_model.ar_count - ar_before, 8);
  endtask

  task automatic read_hit_latency();
    int ar_before;
    int cycles;
    ar_before = mem_model.ar_count;
    load_check(32'h0000_0170, cycles);
    check_count("ar count", mem_model.ar_count - ar_before, 0);
    check_count("o_cpu_done latency", cycles, 2);
  endtask

  task automatic write_hit_strobes();
    int aw_before;
    int cycles;
    aw_before = mem_model.aw_count;
    store_check(32'h0000_0158, {$urandom, $urandom}, 8'h5a);
    load_check(32'h0000_0158, cycles);
    check_count("aw count", mem_model.aw_count - aw_before, 0);
  endtask

  // same index 5, tag 3, victim dirty from the store
  task automatic dirty_eviction();
    int aw_before;
    int cycles;
    aw_before = mem_model.aw_count;
    load_check(32'h0000_0d48, cycles);
    check_count("aw count", mem_model.aw_count - aw_before, 8);
    for (int w = 0; w < 8; w++) begin
      check_word("victim line in memory", model_word(32'h140 + w * 8),
                 expected_word(32'h140 + w * 8));
    end
  endtask

  // tags 0..3 over all indexes and words
  task automatic mixed_sweep();
    logic [31:0] addr;
    int cycles;
    for (int i = 0; i < SWEEP_ACCESSES; i++) begin
      addr = {20'd0, 2'($urandom_range(3, 0)), 4'($urandom_range(15, 0)),
              3'($urandom_range(7, 0)), 3'd0};
      if ($urandom_range(1, 0) == 1) begin
        store_check(addr, {$urandom, $urandom}, 8'($urandom));
      end else begin
        load_check(addr, cycles);
      end
    end
  endtask

  // time budget scales with access count
  initial begin
    repeat (RESET_CYCLES + CYCLES_PER_ACCESS * NUM_ACCESSES) @(posedge clk);
    $display("watchdog expired, a cache access never completed");
    abort_run();
  end

  // bound protocol checker
  initial begin
    wait (dut.u_sva.fail_count != 0);
    $display("a protocol assertion in dcache_sva failed");
    abort_run();
  end

  initial begin
    void'($urandom(SEED));
    rst       = 1'b1;
    cpu_valid = 1'b0;
    cpu_we    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    cpu_wstrb = '0;
    // same preset rule as the memory
    for (int a = 0; a < 65536; a++) begin
      shadow[a] = a[7:0] + a[15:8];
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
    check_flag("o_cpu_ready after reset", cpu_ready, 1'b1);
    check_flag("o_cpu_done after reset", cpu_done, 1'b0);
    check_flag("o_awvalid after reset", awvalid, 1'b0);
    check_flag("o_wvalid after reset", wvalid, 1'b0);
    check_flag("o_arvalid after reset", arvalid, 1'b0);
    check_flag("o_bready after reset", bready, 1'b0);
    check_flag("o_rready after reset", rready, 1'b0);
    read_miss_refill();
    read_hit_latency();
    write_hit_strobes();
    dirty_eviction();
    mixed_sweep();
    if (dut.u_sva.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
